/* source/sdram_pkg.sv */
/* Shared constants and types for the SDRAM port: geometry, command spacing and
   command encoding. Import into any block that needs them. */
package sdram_pkg;

	localparam int BANK_BITS = 2;
	localparam int ROW_BITS = 13;
	localparam int COL_BITS = 8;     // word column, one half bit is appended on the pins
	localparam int ADDR_BITS = 13;

	localparam int CAS_LATENCY = 2;
	localparam int BURST_LENGTH = 2;

	localparam int T_RP = 2;
	localparam int T_RCD = 2;
	localparam int T_RFC = 7;
	localparam int T_MRD = 2;

	localparam int INIT_CYCLES = 100;      // shortened power-up wait
	localparam int REFRESH_INTERVAL = 390;
	localparam int CAPTURE_STAGES = 2;

	localparam int WAIT_BITS = $clog2(INIT_CYCLES + 1);
	localparam int REFRESH_BITS = $clog2(REFRESH_INTERVAL + 1);

	// reserved, write burst mode 0, standard op, cas latency, sequential, burst length
	localparam logic [ADDR_BITS-1:0] MODE_VALUE =
		{6'b000000, 3'(CAS_LATENCY), 1'b0, 3'($clog2(BURST_LENGTH))};
	localparam logic [ADDR_BITS-1:0] PRECHARGE_ALL = ADDR_BITS'(1 << 10); // a10 selects all banks

	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;

	// {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		CMD_LOAD_MODE = 4'b0000,
		CMD_REFRESH   = 4'b0001,
		CMD_PRECHARGE = 4'b0010,
		CMD_ACTIVE    = 4'b0011,
		CMD_WRITE     = 4'b0100,
		CMD_READ      = 4'b0101,
		CMD_NOP       = 4'b0111
	} command_t;

endpackage

/* source/sdram_timer.sv */
/* Command spacing down-counter and refresh interval counter, both driven
   by pulses from the command FSM. */
`timescale 1ns/10ps

module sdram_timer import sdram_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_wait_load,
	input logic [WAIT_BITS-1:0] i_wait_cycles,
	input logic i_refresh_issued,
	output logic o_wait_done,
	output logic o_refresh_due
);

	logic [WAIT_BITS-1:0] wait_count;
	logic [REFRESH_BITS-1:0] refresh_count;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= '0;
			refresh_count <= '0;
		end else begin
			if (i_wait_load)
				wait_count <= i_wait_cycles;
			else if (wait_count != '0)
				wait_count <= wait_count - 1'b1;

			if (i_refresh_issued)
				refresh_count <= '0;
			else if (!o_refresh_due)
				refresh_count <= refresh_count + 1'b1; // saturates at the interval
		end
	end

	// a load in flight hides the stale zero of the previous count
	assign o_wait_done = (wait_count == '0) && !i_wait_load;
	assign o_refresh_due = (refresh_count == REFRESH_BITS'(REFRESH_INTERVAL));

endmodule

/* source/sdram_data_path.sv */
/* SDRAM data bus handling: drives write halves, registers the returning bus
   and assembles the 32-bit read word. */
`timescale 1ns/10ps

module sdram_data_path import sdram_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input word_t i_wdata,
	input logic i_drive_bus,
	input logic i_drive_upper,
	input logic i_capture_lower,
	input logic i_capture_upper,
	inout wire half_t io_sdram_data,
	output word_t o_rdata
);

	half_t write_half;
	half_t capture_stage [CAPTURE_STAGES];

	assign write_half = i_drive_upper ? i_wdata[31:16] : i_wdata[15:0];
	assign io_sdram_data = i_drive_bus ? write_half : 'z; // released outside the write burst

	// input registers ahead of any use of the pad data
	always_ff @(posedge i_clock) begin
		capture_stage[0] <= io_sdram_data;
		for (int i = 1; i < CAPTURE_STAGES; i++) begin
			capture_stage[i] <= capture_stage[i - 1];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_rdata <= '0;
		end else begin
			if (i_capture_lower)
				o_rdata[15:0] <= capture_stage[CAPTURE_STAGES - 1];
			if (i_capture_upper)
				o_rdata[31:16] <= capture_stage[CAPTURE_STAGES - 1];
		end
	end

endmodule

/* source/sdram_command_fsm.sv */
/* Command sequencer: power-up, auto-refresh and one closed-row access per request.
   Owns the ready level seen by the client. */
`timescale 1ns/10ps

module sdram_command_fsm import sdram_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input word_t i_address,
	input logic i_wait_done,
	input logic i_refresh_due,
	output logic o_wait_load,
	output logic [WAIT_BITS-1:0] o_wait_cycles,
	output logic o_refresh_issued,
	output command_t o_command,
	output logic o_cke,
	output logic [BANK_BITS-1:0] o_ba,
	output logic [ADDR_BITS-1:0] o_addr,
	output logic o_drive_bus,
	output logic o_drive_upper,
	output logic o_capture_lower,
	output logic o_capture_upper,
	output logic o_ready
);

	typedef enum logic [3:0] {
		ST_POWER_UP, ST_INIT_PRECHARGE, ST_INIT_REFRESH, ST_LOAD_MODE, ST_IDLE,
		ST_READ, ST_READ_PRECHARGE, ST_CAPTURE_LOWER, ST_CAPTURE_UPPER,
		ST_WRITE, ST_WRITE_UPPER, ST_WRITE_PRECHARGE, ST_DONE
	} state_t;

	state_t state;
	logic second_refresh;               // set once the first init refresh is out
	logic [BANK_BITS-1:0] bank;
	logic [ROW_BITS-1:0] row;
	logic [COL_BITS-1:0] column;

	// the timer load and the decision each take one cycle of the spacing
	function automatic logic [WAIT_BITS-1:0] spacing(input int cycles);
		return WAIT_BITS'(cycles - 2);
	endfunction

	assign {bank, row, column} = i_address[24:2];
	assign o_cke = 1'b1; // no power-down

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_POWER_UP;
			second_refresh <= 1'b0;
			o_command <= CMD_NOP;
			o_wait_load <= 1'b0;
			o_wait_cycles <= '0;
			o_refresh_issued <= 1'b0;
			o_ba <= '0;
			o_addr <= '0;
			o_drive_bus <= 1'b0;
			o_drive_upper <= 1'b0;
			o_capture_lower <= 1'b0;
			o_capture_upper <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			o_command <= CMD_NOP;
			o_wait_load <= 1'b0;
			o_refresh_issued <= 1'b0;
			o_capture_lower <= 1'b0;
			o_capture_upper <= 1'b0;

			// every state acts only once the previous spacing has run out
			if (i_wait_done) begin
				case (state)
				ST_POWER_UP: begin
					o_wait_load <= 1'b1;
					o_wait_cycles <= spacing(INIT_CYCLES);
					state <= ST_INIT_PRECHARGE;
				end
				ST_INIT_PRECHARGE: begin
					o_command <= CMD_PRECHARGE;
					o_addr <= PRECHARGE_ALL;
					o_wait_load <= 1'b1;
					o_wait_cycles <= spacing(T_RP);
					state <= ST_INIT_REFRESH;
				end
				ST_INIT_REFRESH: begin
					o_command <= CMD_REFRESH;
					o_refresh_issued <= 1'b1;
					o_wait_load <= 1'b1;
					o_wait_cycles <= spacing(T_RFC);
					second_refresh <= 1'b1;
					if (second_refresh)
						state <= ST_LOAD_MODE;
				end
				ST_LOAD_MODE: begin
					o_command <= CMD_LOAD_MODE;
					o_ba <= '0;
					o_addr <= MODE_VALUE;
					o_wait_load <= 1'b1;
					o_wait_cycles <= spacing(T_MRD);
					state <= ST_IDLE;
				end
				ST_IDLE: begin
					if (!i_request)
						o_ready <= 1'b0;   // client has seen the completion
					if (i_refresh_due) begin
						o_command <= CMD_REFRESH;
						o_refresh_issued <= 1'b1;
						o_wait_load <= 1'b1;
						o_wait_cycles <= spacing(T_RFC);
					end else if (i_request && !o_ready) begin
						o_command <= CMD_ACTIVE;
						o_ba <= bank;
						o_addr <= row;
						o_wait_load <= 1'b1;
						o_wait_cycles <= spacing(T_RCD);
						state <= i_rw ? ST_WRITE : ST_READ;
					end
				end
				ST_READ: begin
					o_command <= CMD_READ;
					o_addr <= ADDR_BITS'({column, 1'b0}); // a10 low, no auto precharge
					o_wait_load <= 1'b1;
					o_wait_cycles <= spacing(BURST_LENGTH);
					state <= ST_READ_PRECHARGE;
				end
				ST_READ_PRECHARGE: begin
					o_command <= CMD_PRECHARGE; // burst still completes on the bus
					o_addr <= PRECHARGE_ALL;
					o_wait_load <= 1'b1;
					o_wait_cycles <= spacing(CAS_LATENCY + CAPTURE_STAGES - BURST_LENGTH);
					state <= ST_CAPTURE_LOWER;
				end
				ST_CAPTURE_LOWER: begin
					o_capture_lower <= 1'b1;
					state <= ST_CAPTURE_UPPER;
				end
				ST_CAPTURE_UPPER: begin
					o_capture_upper <= 1'b1;
					state <= ST_DONE;
				end
				ST_WRITE: begin
					o_command <= CMD_WRITE;
					o_addr <= ADDR_BITS'({column, 1'b0});
					o_drive_bus <= 1'b1;
					o_drive_upper <= 1'b0;
					state <= ST_WRITE_UPPER;
				end
				ST_WRITE_UPPER: begin
					o_drive_upper <= 1'b1;     // second beat of the burst
					state <= ST_WRITE_PRECHARGE;
				end
				ST_WRITE_PRECHARGE: begin
					o_command <= CMD_PRECHARGE;
					o_addr <= PRECHARGE_ALL;
					o_drive_bus <= 1'b0;
					o_drive_upper <= 1'b0;
					o_wait_load <= 1'b1;
					o_wait_cycles <= spacing(T_RP);
					state <= ST_DONE;
				end
				ST_DONE: begin
					o_ready <= 1'b1;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
				endcase
			end
		end
	end

endmodule

/* source/sdram_interface.sv */
/* Top of the SDRAM port: ties the command FSM, the timer and the data path
   to the client request/ready levels and to the SDRAM pins. */
`timescale 1ns/10ps

module sdram_interface import sdram_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input logic i_request,
	input logic i_rw,                  // 1 = write, 0 = read
	input word_t i_address,            // byte address
	input word_t i_wdata,
	output word_t o_rdata,
	output logic o_ready,

	output logic o_sdram_cke,
	output logic o_sdram_cs_n,
	output logic o_sdram_ras_n,
	output logic o_sdram_cas_n,
	output logic o_sdram_we_n,
	output logic [BANK_BITS-1:0] o_sdram_ba,
	output logic [ADDR_BITS-1:0] o_sdram_addr,
	inout wire half_t io_sdram_data
);

	logic wait_load;
	logic [WAIT_BITS-1:0] wait_cycles;
	logic wait_done;
	logic refresh_issued;
	logic refresh_due;
	command_t command;
	logic drive_bus;
	logic drive_upper;
	logic capture_lower;
	logic capture_upper;

	assign {o_sdram_cs_n, o_sdram_ras_n, o_sdram_cas_n, o_sdram_we_n} = command;

	sdram_command_fsm u_fsm (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wait_done(wait_done),
		.i_refresh_due(refresh_due),
		.o_wait_load(wait_load),
		.o_wait_cycles(wait_cycles),
		.o_refresh_issued(refresh_issued),
		.o_command(command),
		.o_cke(o_sdram_cke),
		.o_ba(o_sdram_ba),
		.o_addr(o_sdram_addr),
		.o_drive_bus(drive_bus),
		.o_drive_upper(drive_upper),
		.o_capture_lower(capture_lower),
		.o_capture_upper(capture_upper),
		.o_ready(o_ready)
	);

	sdram_timer u_timer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wait_load(wait_load),
		.i_wait_cycles(wait_cycles),
		.i_refresh_issued(refresh_issued),
		.o_wait_done(wait_done),
		.o_refresh_due(refresh_due)
	);

	sdram_data_path u_data_path (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wdata(i_wdata),
		.i_drive_bus(drive_bus),
		.i_drive_upper(drive_upper),
		.i_capture_lower(capture_lower),
		.i_capture_upper(capture_upper),
		.io_sdram_data(io_sdram_data),
		.o_rdata(o_rdata)
	);

endmodule

/* sim/sdram_model.sv */
/* Behavioral SDRAM for simulation with CAS latency 2 and a burst of two.
   Halves are kept in an associative array keyed by bank, row and column. */
`timescale 1ns/10ps

module sdram_model import sdram_pkg::*; (
	input logic i_clock,
	input logic i_cke,
	input logic i_cs_n,
	input logic i_ras_n,
	input logic i_cas_n,
	input logic i_we_n,
	input logic [BANK_BITS-1:0] i_ba,
	input logic [ADDR_BITS-1:0] i_addr,
	inout wire half_t io_data
);

	half_t memory [logic [23:0]];          // {bank, row, 9-bit column}
	logic [ROW_BITS-1:0] open_row [1 << BANK_BITS];
	logic [(1 << BANK_BITS)-1:0] row_open = '0;
	logic [ADDR_BITS-1:0] mode = '0;
	command_t command;
	logic [23:0] access_key;
	logic [23:0] write_key;
	logic write_upper = 1'b0;
	logic [23:0] read_key;
	int read_phase = -1;                   // edges since the read command or -1 when idle
	logic drive_enable = 1'b0;
	half_t drive_value;
	int activate_count = 0;
	int protocol_errors = 0;

	assign command = command_t'({i_cs_n, i_ras_n, i_cas_n, i_we_n});
	assign io_data = drive_enable ? drive_value : 'z;

	function automatic half_t lookup(input logic [23:0] k);
		return memory.exists(k) ? memory[k] : 'x;
	endfunction

	always @(posedge i_clock) begin
		access_key = {i_ba, open_row[i_ba], i_addr[8:0]};
		write_upper <= 1'b0;
		if (write_upper)
			memory[write_key + 24'd1] = io_data; // second beat of the burst

		// beat b is valid on the bus at edge CAS_LATENCY + b after the command
		if (read_phase >= 0) begin
			if (read_phase >= CAS_LATENCY - 2 && read_phase < CAS_LATENCY - 2 + BURST_LENGTH) begin
				drive_enable <= 1'b1;
				drive_value <= lookup(read_key + 24'(read_phase - (CAS_LATENCY - 2)));
				read_phase <= read_phase + 1;
			end else begin
				drive_enable <= 1'b0;
				read_phase <= -1;
			end
		end

		if (i_cke) begin
			case (command)
			CMD_ACTIVE: begin
				if (row_open[i_ba])
					protocol_errors <= protocol_errors + 1;
				open_row[i_ba] <= i_addr;
				row_open[i_ba] <= 1'b1;
				activate_count <= activate_count + 1;
			end
			CMD_PRECHARGE: begin
				if (i_addr[10])
					row_open <= '0;
				else
					row_open[i_ba] <= 1'b0;
			end
			CMD_REFRESH: begin
				if (row_open != '0)
					protocol_errors <= protocol_errors + 1; // refresh needs all banks idle
			end
			CMD_LOAD_MODE: mode <= i_addr;
			CMD_WRITE: begin
				if (!row_open[i_ba])
					protocol_errors <= protocol_errors + 1;
				memory[access_key] = io_data;
				write_key <= access_key;
				write_upper <= 1'b1;
			end
			CMD_READ: begin
				if (!row_open[i_ba] || mode[6:4] != 3'(CAS_LATENCY) ||
						mode[2:0] != 3'($clog2(BURST_LENGTH)))
					protocol_errors <= protocol_errors + 1;
				read_key <= access_key;
				read_phase <= 0;
			end
			default: ;
			endcase
		end
	end

endmodule

/* sim/sdram_interface_sva.sv */
/* Assertions on the command pins and the request/ready levels, bound into
   every sdram_command_fsm instance. */
`timescale 1ns/10ps

module sdram_interface_sva import sdram_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic o_ready,
	input logic o_drive_bus,
	input command_t o_command
);

	// with T_RCD = 2 exactly one nop fits before the column command
	activate_spacing: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_command == CMD_ACTIVE) |=> (o_command == CMD_NOP))
		else $error("command issued inside the activate to column delay");

	ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_ready) |-> $past(i_request))
		else $error("ready rose without a pending request");

	bus_drive_window: assert property (@(posedge i_clock) disable iff (i_reset)
		o_drive_bus |-> (o_command == CMD_WRITE) || ($past(o_command) == CMD_WRITE))
		else $error("data bus driven outside the write burst");

endmodule

bind sdram_command_fsm sdram_interface_sva u_sva (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_request(i_request),
	.o_ready(o_ready),
	.o_drive_bus(o_drive_bus),
	.o_command(o_command)
);

/* sim/tb_sdram.sv */
/* Testbench for the SDRAM port. It replays the access vectors, checks the ready
   level, counts refreshes and runs a random write/read sweep. */
`timescale 1ns/10ps

module tb_sdram import sdram_pkg::*; ();

	localparam int READY_TIMEOUT = 2000;   // in cycles and long enough for init plus a refresh
	localparam int HOLD_CYCLES = 3;
	localparam int SWEEP_WORDS = 32;

	logic clock;
	logic reset;
	logic request;
	logic rw;
	word_t address;
	word_t wdata;
	word_t rdata;
	logic ready;
	logic sdram_cke;
	logic sdram_cs_n;
	logic sdram_ras_n;
	logic sdram_cas_n;
	logic sdram_we_n;
	logic [BANK_BITS-1:0] sdram_ba;
	logic [ADDR_BITS-1:0] sdram_addr;
	wire half_t sdram_data;

	logic [31:0] lcg_state;
	word_t read_word;
	word_t sweep_address [SWEEP_WORDS];
	word_t sweep_data [SWEEP_WORDS];
	word_t reread_address [$];
	word_t reread_expected [$];

	sdram_interface i_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_sdram_cke(sdram_cke),
		.o_sdram_cs_n(sdram_cs_n),
		.o_sdram_ras_n(sdram_ras_n),
		.o_sdram_cas_n(sdram_cas_n),
		.o_sdram_we_n(sdram_we_n),
		.o_sdram_ba(sdram_ba),
		.o_sdram_addr(sdram_addr),
		.io_sdram_data(sdram_data)
	);

	sdram_model u_model (
		.i_clock(clock),
		.i_cke(sdram_cke),
		.i_cs_n(sdram_cs_n),
		.i_ras_n(sdram_ras_n),
		.i_cas_n(sdram_cas_n),
		.i_we_n(sdram_we_n),
		.i_ba(sdram_ba),
		.i_addr(sdram_addr),
		.io_data(sdram_data)
	);

	always #4 clock = ~clock;

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("Error: %s expected %0d actual %0d", name, expected, actual);
			$display("Test failed");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic check_range(input string name, input int low, input int high,
			input int actual);
		if (actual < low || actual > high) begin
			$display("Error: %s expected %0d to %0d actual %0d", name, low, high, actual);
			$display("Test failed");
			$fatal(1, "count out of range");
		end
	endtask

	task automatic wait_ready(input logic level, input string name);
		int cycles;
		cycles = 0;
		while (ready !== level) begin
			@(posedge clock);
			cycles++;
			if (cycles > READY_TIMEOUT)
				stop_run($sformatf("%s: ready did not go to %0d in time", name, level));
		end
	endtask

	// one full request/ready handshake with ready held a few cycles before release
	task automatic access(input string name, input logic write, input word_t addr,
			input word_t data, output word_t result);
		int activates_before;
		activates_before = u_model.activate_count;
		request <= 1'b1;
		rw <= write;
		address <= addr;
		wdata <= data;
		wait_ready(1'b1, name);
		result = rdata;
		repeat (HOLD_CYCLES) begin
			@(posedge clock);
			check_count({name, " ready held"}, 1, int'(ready));
		end
		request <= 1'b0;
		wait_ready(1'b0, name);
		check_count({name, " activates"}, 1, u_model.activate_count - activates_before);
	endtask

	task automatic replay_vectors();
		int fd;
		int fields;
		int line_number;
		string line;
		word_t op;
		word_t vec_address;
		word_t vec_wdata;
		word_t vec_expected;
		line_number = 0;
		fd = $fopen("sim/sdram_vectors.txt", "r");
		if (fd == 0)
			stop_run("cannot open sim/sdram_vectors.txt");
		while ($fgets(line, fd) > 0) begin
			line_number++;
			if (line.len() < 2 || line[0] == "#")
				continue;
			fields = $sscanf(line, "%h %h %h %h", op, vec_address, vec_wdata, vec_expected);
			if (fields != 4)
				stop_run($sformatf("malformed vector on line %0d", line_number));
			if (op[0]) begin
				access($sformatf("vector line %0d write", line_number), 1'b1, vec_address,
					vec_wdata, read_word);
			end else begin
				access($sformatf("vector line %0d read", line_number), 1'b0, vec_address,
					'0, read_word);
				check_word($sformatf("vector line %0d read", line_number), vec_expected, read_word);
				reread_address.push_back(vec_address);
				reread_expected.push_back(vec_expected);
			end
		end
		$fclose(fd);
	endtask

	task automatic count_refreshes();
		int refreshes;
		refreshes = 0;
		for (int i = 0; i < 4 * REFRESH_INTERVAL; i++) begin
			@(posedge clock);
			if (command_t'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n}) == CMD_REFRESH)
				refreshes++;
		end
		check_range("refreshes in idle window", 3, 5, refreshes);
	endtask

	// random idle gaps slide the reads across the refresh schedule
	task automatic reread_with_gaps();
		int gap;
		foreach (reread_address[i]) begin
			lcg_state = next_random(lcg_state);
			gap = int'(lcg_state[23:16]);
			repeat (gap) @(posedge clock);
			access($sformatf("reread %0d", i), 1'b0, reread_address[i], '0, read_word);
			check_word($sformatf("reread %0d", i), reread_expected[i], read_word);
		end
	endtask

	task automatic random_sweep();
		logic [4:0] slot;
		int index;
		for (int i = 0; i < SWEEP_WORDS; i++) begin
			slot = 5'(i);
			lcg_state = next_random(lcg_state);
			sweep_data[i] = lcg_state;
			lcg_state = next_random(lcg_state);
			// the slot number sets the bank and upper row bits so no two addresses collide
			sweep_address[i] = {7'd0, slot[1:0], slot[4:2], lcg_state[19:10], lcg_state[27:20],
				2'b00};
			access($sformatf("sweep write %0d", i), 1'b1, sweep_address[i], sweep_data[i],
				read_word);
		end
		for (int i = 0; i < SWEEP_WORDS; i++) begin
			index = (i * 13) % SWEEP_WORDS;
			access($sformatf("sweep read %0d", index), 1'b0, sweep_address[index], '0, read_word);
			check_word($sformatf("sweep read %0d", index), sweep_data[index], read_word);
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		lcg_state = 32'h0917_1c8d;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check_count("ready after reset", 0, int'(ready));
		check_count("cke after reset", 1, int'(sdram_cke));

		replay_vectors();
		count_refreshes();
		reread_with_gaps();
		random_sweep();

		check_count("model protocol errors", 0, u_model.protocol_errors);
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* verilog.f */
source/sdram_pkg.sv
source/sdram_timer.sv
source/sdram_data_path.sv
source/sdram_command_fsm.sv
source/sdram_interface.sv
sim/sdram_model.sv
sim/sdram_interface_sva.sv
sim/tb_sdram.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_sdram -f verilog.f -o tb_sdram > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build did not complete"
	exit 1
fi

./obj_dir/tb_sdram > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test completed successfully" "$SIM_LOG"; then
	exit 0
fi

echo "pass message not found in $SIM_LOG"
exit 1

/* sim/sdram_vectors.txt */
# op (1 = write, 0 = read), byte address, write data, expected read data
# all values hex, writes ignore the last column and reads ignore the write data
1 00000000 a5a51234 00000000
1 000003fc 0badf00d 00000000
1 00000400 76543210 00000000
1 008003fc 24681357 00000000
1 00800400 13572468 00000000
1 00800404 5a5a5a5a 00000000
1 01000ffc cafe0001 00000000
1 01fffffc ffff0000 00000000
0 00000000 00000000 a5a51234
0 000003fc 00000000 0badf00d
0 00000400 00000000 76543210
0 01000ffc 00000000 cafe0001
0 01fffffc 00000000 ffff0000
1 00800400 9abcdef0 00000000
0 008003fc 00000000 24681357
0 00800400 00000000 9abcdef0
0 00800404 00000000 5a5a5a5a
